/* source/synth_consts.svh */
//------------------------------------------------------------
// constants shared by the scan-code tone synthesizer
// key codes, step periods, table geometry and the APB map
//------------------------------------------------------------
`ifndef SYNTH_CONSTS_SVH
`define SYNTH_CONSTS_SVH

// output sample width, two's complement
`define SYNTH_SAMPLE_W 16

// one sine period is 48 phase steps
`define SYNTH_TABLE_LEN 48
`define SYNTH_PHASE_W 6

// keys mapped, C1 up to C2
`define SYNTH_NOTE_COUNT 13

// prefix byte ahead of a key release
`define SYNTH_RELEASE_CODE 8'hf0

// make codes in note order
`define SYNTH_KEY_C1 8'h15
`define SYNTH_KEY_DF1 8'h1e
`define SYNTH_KEY_D1 8'h1d
`define SYNTH_KEY_EF1 8'h26
`define SYNTH_KEY_E1 8'h24
`define SYNTH_KEY_F1 8'h2d
`define SYNTH_KEY_GF1 8'h2e
`define SYNTH_KEY_G1 8'h2c
`define SYNTH_KEY_AF1 8'h36
`define SYNTH_KEY_A1 8'h35
`define SYNTH_KEY_BF1 8'h3d
`define SYNTH_KEY_B1 8'h3c
`define SYNTH_KEY_C2 8'h43

// clk_1M cycles per phase step
// even ladder of 8, last rung 4
`define SYNTH_STEP_C1 8'd160
`define SYNTH_STEP_DF1 8'd152
`define SYNTH_STEP_D1 8'd144
`define SYNTH_STEP_EF1 8'd136
`define SYNTH_STEP_E1 8'd128
`define SYNTH_STEP_F1 8'd120
`define SYNTH_STEP_GF1 8'd112
`define SYNTH_STEP_G1 8'd104
`define SYNTH_STEP_AF1 8'd96
`define SYNTH_STEP_A1 8'd88
`define SYNTH_STEP_BF1 8'd80
`define SYNTH_STEP_B1 8'd72
`define SYNTH_STEP_C2 8'd68

// APB register offsets
`define SYNTH_ADDR_CTRL 4'h0
`define SYNTH_ADDR_STATUS 4'h4

`endif

/* source/synth_pkg.sv */
//------------------------------------------------------------
// packed types passed between the synthesizer blocks
//------------------------------------------------------------
`default_nettype none

package synth_pkg;

	// request from a held key
	// note counts up from C1 = 0
	typedef struct packed {
		logic active;
		logic [3:0] note;
	} note_req_t;

	// control register
	// enable sits in bit 0, full_volume in bit 1
	typedef struct packed {
		logic full_volume;
		logic enable;
	} synth_ctrl_t;

	// status register, read only
	// active in bit 4, note in bits 3..0
	typedef struct packed {
		logic active;
		logic [3:0] note;
	} synth_status_t;

endpackage

`default_nettype wire

/* source/synth_apb_regs.sv */
//------------------------------------------------------------
// APB slave for the synthesizer, zero wait states
// CTRL is read/write, STATUS is read only
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "synth_consts.svh"

module synth_apb_regs (
	input logic clk_1M,
	input logic rst,
	input logic [3:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	input synth_pkg::synth_status_t status,
	output synth_pkg::synth_ctrl_t ctrl
);

	logic setup;
	logic access;
	logic hit_ctrl;
	logic hit_status;
	logic bad;

	// APB phases
	assign setup = psel && !penable;
	assign access = psel && penable;

	// address decode
	assign hit_ctrl = (paddr == `SYNTH_ADDR_CTRL);
	assign hit_status = (paddr == `SYNTH_ADDR_STATUS);
	// unknown offset, or a write to the read-only status
	assign bad = !(hit_ctrl || hit_status) || (pwrite && hit_status);

	// never stalls
	assign pready = 1'b1;

	// control register, written at the end of the access cycle
	always_ff @(posedge clk_1M)
	begin
		if (rst)
			ctrl <= '0;
		else if (access && pwrite && hit_ctrl)
			ctrl <= pwdata[$bits(synth_pkg::synth_ctrl_t)-1:0];
	end

	// read data and error are loaded in setup
	// so both are valid through the access cycle
	always_ff @(posedge clk_1M)
	begin
		if (rst)
		begin
			prdata <= '0;
			pslverr <= 1'b0;
		end
		else
		begin
			pslverr <= setup && bad;
			if (setup && !pwrite && hit_ctrl)
				prdata <= 32'(ctrl);
			else if (setup && !pwrite && hit_status)
				prdata <= 32'(status);
			else
				prdata <= '0;
		end
	end

	// access phase only ever follows a selected setup
	assert property (@(posedge clk_1M) disable iff (rst) penable |-> psel)
		else $error("penable high while psel low");

endmodule

`default_nettype wire

/* source/key_decoder.sv */
//------------------------------------------------------------
// scan-code word to note request
// low byte is the make code, high byte the prefix
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "synth_consts.svh"

module key_decoder (
	input logic clk_1M,
	input logic rst,
	input logic [15:0] key_press,
	output synth_pkg::note_req_t req
);

	logic [15:0] key_q;
	logic hit;
	logic [3:0] note;
	logic released;

	// capture the incoming word
	always_ff @(posedge clk_1M)
	begin
		if (rst)
			key_q <= '0;
		else
			key_q <= key_press;
	end

	// make code lookup, one octave only
	always_comb
	begin
		hit = 1'b1;
		note = 4'd0;
		case (key_q[7:0])
			`SYNTH_KEY_C1: note = 4'd0;
			`SYNTH_KEY_DF1: note = 4'd1;
			`SYNTH_KEY_D1: note = 4'd2;
			`SYNTH_KEY_EF1: note = 4'd3;
			`SYNTH_KEY_E1: note = 4'd4;
			`SYNTH_KEY_F1: note = 4'd5;
			`SYNTH_KEY_GF1: note = 4'd6;
			`SYNTH_KEY_G1: note = 4'd7;
			`SYNTH_KEY_AF1: note = 4'd8;
			`SYNTH_KEY_A1: note = 4'd9;
			`SYNTH_KEY_BF1: note = 4'd10;
			`SYNTH_KEY_B1: note = 4'd11;
			`SYNTH_KEY_C2: note = 4'd12;
			default: hit = 1'b0;
		endcase
	end

	// f0 ahead of the code means the key went up
	assign released = (key_q[15:8] == `SYNTH_RELEASE_CODE);

	// note is parked at 0 when nothing is held
	always_ff @(posedge clk_1M)
	begin
		if (rst)
			req <= '0;
		else
		begin
			req.active <= hit && !released;
			req.note <= (hit && !released) ? note : 4'd0;
		end
	end

	// a live request always names one of the mapped notes
	assert property (@(posedge clk_1M) disable iff (rst)
		req.active |-> (req.note < `SYNTH_NOTE_COUNT))
		else $error("note number out of range");

endmodule

`default_nettype wire

/* source/tone_stepper.sv */
//------------------------------------------------------------
// phase generator, steps the sine index once per note period
// replaces the per-note divided clocks with one counter
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "synth_consts.svh"

module tone_stepper (
	input logic clk_1M,
	input logic rst,
	input synth_pkg::note_req_t req,
	input synth_pkg::synth_ctrl_t ctrl,
	output logic [`SYNTH_PHASE_W-1:0] phase,
	output logic idle,
	output synth_pkg::synth_status_t status
);

	localparam int CNT_W = 8;
	localparam int LAST = `SYNTH_TABLE_LEN - 1;
	localparam logic [`SYNTH_PHASE_W-1:0] LAST_PHASE = LAST[`SYNTH_PHASE_W-1:0];

	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] count_eff;
	logic [CNT_W-1:0] period;
	logic [3:0] note_q;
	logic active_q;
	logic run;
	logic restart;
	logic step;

	// cycles per phase step for the held note
	always_comb
	begin
		case (req.note)
			4'd0: period = `SYNTH_STEP_C1;
			4'd1: period = `SYNTH_STEP_DF1;
			4'd2: period = `SYNTH_STEP_D1;
			4'd3: period = `SYNTH_STEP_EF1;
			4'd4: period = `SYNTH_STEP_E1;
			4'd5: period = `SYNTH_STEP_F1;
			4'd6: period = `SYNTH_STEP_GF1;
			4'd7: period = `SYNTH_STEP_G1;
			4'd8: period = `SYNTH_STEP_AF1;
			4'd9: period = `SYNTH_STEP_A1;
			4'd10: period = `SYNTH_STEP_BF1;
			4'd11: period = `SYNTH_STEP_B1;
			4'd12: period = `SYNTH_STEP_C2;
			default: period = `SYNTH_STEP_C1;
		endcase
	end

	assign run = req.active && ctrl.enable;
	// new note or fresh press, count from zero in this same cycle
	assign restart = (req.note != note_q) || (req.active && !active_q);
	assign count_eff = restart ? '0 : count;
	assign step = (count_eff == period - 1'b1);

	always_ff @(posedge clk_1M)
	begin
		if (rst)
		begin
			count <= '0;
			phase <= '0;
			idle <= 1'b1;
			note_q <= 4'd0;
			active_q <= 1'b0;
		end
		else
		begin
			note_q <= req.note;
			active_q <= req.active;
			// lines up with phase for the ROM stage
			idle <= !run;
			if (!run)
			begin
				count <= '0;
				phase <= '0;
			end
			else if (step)
			begin
				count <= '0;
				phase <= (phase == LAST_PHASE) ? '0 : phase + 1'b1;
			end
			else
				count <= count_eff + 1'b1;
		end
	end

	// status follows the request while enabled
	assign status.active = run;
	assign status.note = run ? req.note : 4'd0;

	assert property (@(posedge clk_1M) disable iff (rst) phase <= LAST_PHASE)
		else $error("phase past end of sine table");

endmodule

`default_nettype wire

/* source/sine_rom.sv */
//------------------------------------------------------------
// 48-entry sine table, registered output
// full scale 32767, halved when full_volume is clear
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "synth_consts.svh"

module sine_rom (
	input logic clk_1M,
	input logic rst,
	input logic [`SYNTH_PHASE_W-1:0] phase,
	input logic idle,
	input synth_pkg::synth_ctrl_t ctrl,
	output logic signed [`SYNTH_SAMPLE_W-1:0] sample
);

	logic signed [`SYNTH_SAMPLE_W-1:0] full;

	// round(32767 * sin(2*pi*i/48))
	always_comb
	begin
		case (phase)
			6'd0: full = 16'sd0;
			6'd1: full = 16'sd4277;
			6'd2: full = 16'sd8481;
			6'd3: full = 16'sd12539;
			6'd4: full = 16'sd16383;
			6'd5: full = 16'sd19947;
			6'd6: full = 16'sd23170;
			6'd7: full = 16'sd25996;
			6'd8: full = 16'sd28377;
			6'd9: full = 16'sd30273;
			6'd10: full = 16'sd31650;
			6'd11: full = 16'sd32487;
			6'd12: full = 16'sd32767;
			6'd13: full = 16'sd32487;
			6'd14: full = 16'sd31650;
			6'd15: full = 16'sd30273;
			6'd16: full = 16'sd28377;
			6'd17: full = 16'sd25996;
			6'd18: full = 16'sd23170;
			6'd19: full = 16'sd19947;
			6'd20: full = 16'sd16383;
			6'd21: full = 16'sd12539;
			6'd22: full = 16'sd8481;
			6'd23: full = 16'sd4277;
			// negative half cycle
			6'd24: full = 16'sd0;
			6'd25: full = -16'sd4277;
			6'd26: full = -16'sd8481;
			6'd27: full = -16'sd12539;
			6'd28: full = -16'sd16384;
			6'd29: full = -16'sd19947;
			6'd30: full = -16'sd23170;
			6'd31: full = -16'sd25996;
			6'd32: full = -16'sd28377;
			6'd33: full = -16'sd30273;
			6'd34: full = -16'sd31650;
			6'd35: full = -16'sd32487;
			6'd36: full = -16'sd32767;
			6'd37: full = -16'sd32487;
			6'd38: full = -16'sd31650;
			6'd39: full = -16'sd30273;
			6'd40: full = -16'sd28377;
			6'd41: full = -16'sd25996;
			6'd42: full = -16'sd23170;
			6'd43: full = -16'sd19947;
			6'd44: full = -16'sd16384;
			6'd45: full = -16'sd12539;
			6'd46: full = -16'sd8481;
			6'd47: full = -16'sd4277;
			default: full = '0;
		endcase
	end

	// silent while idle, half volume is a signed shift
	always_ff @(posedge clk_1M)
	begin
		if (rst)
			sample <= '0;
		else if (idle)
			sample <= '0;
		else if (ctrl.full_volume)
			sample <= full;
		else
			sample <= full >>> 1;
	end

endmodule

`default_nettype wire

/* source/synth_top.sv */
//------------------------------------------------------------
// top of the tone synthesizer
// scan code in, signed sample out, APB for control and status
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "synth_consts.svh"

module synth_top (
	input logic clk_1M,
	input logic rst,
	input logic [15:0] key_press,
	input logic [3:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic signed [`SYNTH_SAMPLE_W-1:0] sample
);

	synth_pkg::synth_ctrl_t ctrl;
	synth_pkg::synth_status_t status;
	synth_pkg::note_req_t req;
	logic [`SYNTH_PHASE_W-1:0] phase;
	logic idle;

	// register block
	synth_apb_regs u_regs (
		.clk_1M(clk_1M),
		.rst(rst),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.status(status),
		.ctrl(ctrl)
	);

	// two cycles from key word to request
	key_decoder u_keys (
		.clk_1M(clk_1M),
		.rst(rst),
		.key_press(key_press),
		.req(req)
	);

	tone_stepper u_stepper (
		.clk_1M(clk_1M),
		.rst(rst),
		.req(req),
		.ctrl(ctrl),
		.phase(phase),
		.idle(idle),
		.status(status)
	);

	// one more cycle from phase to sample
	sine_rom u_rom (
		.clk_1M(clk_1M),
		.rst(rst),
		.phase(phase),
		.idle(idle),
		.ctrl(ctrl),
		.sample(sample)
	);

endmodule

`default_nettype wire

/* sim/synth_tb.sv */
//------------------------------------------------------------
// directed testbench for the scan-code tone synthesizer
// drives key words and APB, checks samples against a sine model
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "synth_consts.svh"

module synth_tb;

	localparam int CLK_PERIOD = 100;
	localparam logic [31:0] SEED = 32'h872ef769;
	localparam real PI = 3.141592653589793;
	// longest wave is C1, two full waves in the full volume test
	localparam int WAVE_MAX = `SYNTH_TABLE_LEN * `SYNTH_STEP_C1;
	localparam int WATCHDOG_CYCLES = 3 * WAVE_MAX + 12 * `SYNTH_STEP_C1 + 2000;

	// make codes and step periods, C1 first
	localparam logic [7:0] KEY_CODES [13] = '{
		`SYNTH_KEY_C1, `SYNTH_KEY_DF1, `SYNTH_KEY_D1, `SYNTH_KEY_EF1, `SYNTH_KEY_E1,
		`SYNTH_KEY_F1, `SYNTH_KEY_GF1, `SYNTH_KEY_G1, `SYNTH_KEY_AF1, `SYNTH_KEY_A1,
		`SYNTH_KEY_BF1, `SYNTH_KEY_B1, `SYNTH_KEY_C2};
	localparam logic [7:0] STEP_TABLE [13] = '{
		`SYNTH_STEP_C1, `SYNTH_STEP_DF1, `SYNTH_STEP_D1, `SYNTH_STEP_EF1, `SYNTH_STEP_E1,
		`SYNTH_STEP_F1, `SYNTH_STEP_GF1, `SYNTH_STEP_G1, `SYNTH_STEP_AF1, `SYNTH_STEP_A1,
		`SYNTH_STEP_BF1, `SYNTH_STEP_B1, `SYNTH_STEP_C2};

	logic clk_1M;
	logic rst;
	logic [15:0] key_press;
	logic [3:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic signed [`SYNTH_SAMPLE_W-1:0] sample;

	int errors;
	int tests_run;
	int tests_failed;
	int test_start_errors;

	synth_top DUT (
		.clk_1M(clk_1M),
		.rst(rst),
		.key_press(key_press),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.sample(sample)
	);

	initial
		clk_1M = 1'b0;
	always #(CLK_PERIOD / 2) clk_1M = ~clk_1M;

	// run limit, all tests back to back plus margin
	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
		$display("Regression failed");
		$finish;
	end

	// round(32767 * sin(2*pi*i/48)), exact halves go toward minus infinity
	function automatic logic signed [`SYNTH_SAMPLE_W-1:0] sine_value(input int i);
		real x;
		int v;
		x = 32767.0 * $sin(2.0 * PI * i / `SYNTH_TABLE_LEN);
		// small bias so $sin error cannot push a tie to the other side
		v = $rtoi($ceil(x - 0.5 - 1.0e-6));
		return 16'(v);
	endfunction

	task automatic compare_word(input string name, input logic [31:0] got,
		input logic [31:0] want);
		assert (got === want)
		else
		begin
			$display("Error: %s = %h, expected %h", name, got, want);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic want);
		assert (got === want)
		else
		begin
			$display("Error: %s = %h, expected %h", name, got, want);
			errors++;
		end
	endtask

	task automatic verify_sample(input logic signed [`SYNTH_SAMPLE_W-1:0] want, input int cycle);
		assert (sample === want)
		else
		begin
			$display("Error: sample = %h, expected %h at cycle %0d", sample, want, cycle);
			errors++;
		end
	endtask

	task automatic start_test();
		test_start_errors = errors;
		tests_run++;
	endtask

	task automatic finish_test(input string name);
		if (errors == test_start_errors)
			$display("%s: pass", name);
		else
		begin
			tests_failed++;
			$display("%s: %0d mismatches", name, errors - test_start_errors);
		end
	endtask

	// setup cycle, then access with the response valid mid cycle
	task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, output logic err);
		@(posedge clk_1M);
		paddr <= addr;
		pwdata <= data;
		pwrite <= 1'b1;
		psel <= 1'b1;
		penable <= 1'b0;
		@(posedge clk_1M);
		penable <= 1'b1;
		@(negedge clk_1M);
		check_flag("pready", pready, 1'b1);
		err = pslverr;
		@(posedge clk_1M);
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
	endtask

	task automatic apb_read(input logic [3:0] addr, output logic [31:0] data, output logic err);
		@(posedge clk_1M);
		paddr <= addr;
		pwrite <= 1'b0;
		psel <= 1'b1;
		penable <= 1'b0;
		@(posedge clk_1M);
		penable <= 1'b1;
		@(negedge clk_1M);
		check_flag("pready", pready, 1'b1);
		data = prdata;
		err = pslverr;
		@(posedge clk_1M);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic hold_key(input logic [15:0] word);
		@(posedge clk_1M);
		key_press <= word;
	endtask

	// f0 prefix, then let the pipeline drain
	task automatic release_key(input int note);
		hold_key({`SYNTH_RELEASE_CODE, KEY_CODES[note]});
		repeat (4) @(posedge clk_1M);
	endtask

	task automatic stay_silent(input int cycles);
		int j;
		for (j = 0; j < cycles; j++)
		begin
			@(negedge clk_1M);
			verify_sample('0, j);
		end
	endtask

	// j counts negedges after the key word is driven
	// captured one edge later, req the edge after, first step a period on, then the ROM stage
	task automatic walk_waves(input int note, input int waves, input bit half);
		int period;
		int last;
		int p;
		int j;
		int start;
		logic signed [`SYNTH_SAMPLE_W-1:0] want;
		period = int'(STEP_TABLE[note]);
		last = 4 + (waves * `SYNTH_TABLE_LEN + 1) * period;
		start = errors;
		hold_key({8'h00, KEY_CODES[note]});
		for (j = 1; j < last && errors == start; j++)
		begin
			@(negedge clk_1M);
			p = (j < 4) ? 0 : (j - 4) / period;
			want = sine_value(p % `SYNTH_TABLE_LEN);
			if (half)
				want = want >>> 1;
			verify_sample(want, j);
		end
		release_key(note);
	endtask

	task automatic reset_state_check();
		logic [31:0] data;
		logic err;
		start_test();
		@(negedge clk_1M);
		verify_sample('0, 0);
		apb_read(`SYNTH_ADDR_CTRL, data, err);
		compare_word("prdata", data, 32'h0);
		check_flag("pslverr", err, 1'b0);
		apb_read(`SYNTH_ADDR_STATUS, data, err);
		compare_word("prdata", data, 32'h0);
		check_flag("pslverr", err, 1'b0);
		// enable in bit 0, full_volume in bit 1
		apb_write(`SYNTH_ADDR_CTRL, 32'h3, err);
		check_flag("pslverr", err, 1'b0);
		apb_read(`SYNTH_ADDR_CTRL, data, err);
		compare_word("prdata", data, 32'h3);
		finish_test("reset and control readback");
	endtask

	task automatic full_volume_wave();
		int n;
		logic err;
		start_test();
		n = $urandom_range(12, 0);
		apb_write(`SYNTH_ADDR_CTRL, 32'h3, err);
		walk_waves(n, 2, 1'b0);
		finish_test($sformatf("full volume wave, note %0d", n));
	endtask

	task automatic ignored_keys();
		int n;
		logic [31:0] data;
		logic err;
		start_test();
		apb_write(`SYNTH_ADDR_CTRL, 32'h3, err);
		// release word for a mapped key
		hold_key({`SYNTH_RELEASE_CODE, `SYNTH_KEY_A1});
		stay_silent(int'(`SYNTH_STEP_C1) + 10);
		apb_read(`SYNTH_ADDR_STATUS, data, err);
		compare_word("prdata", data, 32'h0);
		// make code outside the octave
		hold_key(16'h001c);
		stay_silent(int'(`SYNTH_STEP_C1) + 10);
		apb_read(`SYNTH_ADDR_STATUS, data, err);
		compare_word("prdata", data, 32'h0);
		n = $urandom_range(12, 0);
		hold_key({8'h00, KEY_CODES[n]});
		repeat (4) @(posedge clk_1M);
		apb_read(`SYNTH_ADDR_STATUS, data, err);
		compare_word("prdata", data, {27'd0, 1'b1, 4'(n)});
		release_key(n);
		finish_test($sformatf("release and unmapped keys, status note %0d", n));
	endtask

	task automatic half_volume_wave();
		int n;
		logic err;
		start_test();
		n = $urandom_range(12, 0);
		apb_write(`SYNTH_ADDR_CTRL, 32'h1, err);
		walk_waves(n, 1, 1'b1);
		finish_test($sformatf("half volume wave, note %0d", n));
	endtask

	task automatic disable_while_held();
		int n;
		int period;
		int waited;
		logic [31:0] data;
		logic err;
		start_test();
		n = $urandom_range(12, 0);
		period = int'(STEP_TABLE[n]);
		apb_write(`SYNTH_ADDR_CTRL, 32'h3, err);
		hold_key({8'h00, KEY_CODES[n]});
		waited = 0;
		do
		begin
			@(negedge clk_1M);
			waited++;
		end
		while (sample == 0 && waited < 3 * period);
		assert (sample != 0)
		else
		begin
			$display("no tone started within %0d cycles of the key press", waited);
			errors++;
		end
		apb_write(`SYNTH_ADDR_CTRL, 32'h2, err);
		// CTRL updates at the access edge, then idle, then the sample register
		waited = 0;
		do
		begin
			@(negedge clk_1M);
			waited++;
		end
		while (sample != 0 && waited < 6);
		assert (sample == 0 && waited <= 3)
		else
		begin
			$display("sample still nonzero %0d cycles after enable was cleared", waited);
			errors++;
		end
		stay_silent(2 * period);
		apb_read(`SYNTH_ADDR_STATUS, data, err);
		compare_word("prdata", data, 32'h0);
		release_key(n);
		finish_test($sformatf("disable while held, note %0d", n));
	endtask

	task automatic bad_access();
		logic [31:0] data;
		logic err;
		start_test();
		apb_write(`SYNTH_ADDR_CTRL, 32'h3, err);
		check_flag("pslverr", err, 1'b0);
		apb_read(4'h8, data, err);
		check_flag("pslverr", err, 1'b1);
		// status is read only
		apb_write(`SYNTH_ADDR_STATUS, 32'h0, err);
		check_flag("pslverr", err, 1'b1);
		apb_write(4'hc, 32'h0, err);
		check_flag("pslverr", err, 1'b1);
		apb_read(`SYNTH_ADDR_CTRL, data, err);
		compare_word("prdata", data, 32'h3);
		check_flag("pslverr", err, 1'b0);
		finish_test("bad address and status write");
	endtask

	initial
	begin
		void'($urandom(SEED));
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		test_start_errors = 0;
		rst = 1'b1;
		key_press = 16'h0000;
		paddr = 4'h0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = 32'h0;
		repeat (3) @(posedge clk_1M);
		rst <= 1'b0;

		reset_state_check();
		full_volume_wave();
		ignored_keys();
		half_volume_wave();
		disable_while_held();
		bad_access();

		$display("tests run %0d, tests failed %0d, mismatches %0d",
			tests_run, tests_failed, errors);
		if (tests_failed == 0 && errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
+incdir+source
source/synth_pkg.sv
source/synth_apb_regs.sv
source/key_decoder.sv
source/tone_stepper.sv
source/sine_rom.sv
source/synth_top.sv
sim/synth_tb.sv

/* run.sh */
#!/bin/sh
# build and run the synthesizer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=synth_tb_sim

verilator --binary --timing --assert -f tb.f --top-module synth_tb -Mdir obj_dir -o "$BIN"
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Regression passed" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1
